/* design/ooo_macros.svh */
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// Register file sizes
`define ARCH_REGS   8
`define PHYS_REGS   16

// Queue depths
`define ROB_DEPTH   8
`define IQ_DEPTH    4
`define INQ_DEPTH   4

// Starting credit count of the retire side
`define OUT_CREDITS 4

// Datapath widths
`define XLEN        32
`define IMM_W       16

`endif

/* design/ooo_pkg.sv */
`default_nettype none

`include "ooo_macros.svh"

package ooo_pkg;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_ADDI = 3'd5
    } alu_op_e;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_id_t;

    // Pre-decoded op as it enters the instruction queue
    typedef struct packed {
        alu_op_e          op;
        arch_reg_t        rd;
        arch_reg_t        rs1;
        arch_reg_t        rs2;
        logic [`IMM_W-1:0] imm;
    } uop_t;

    // Renamed op held in the issue queue
    typedef struct packed {
        alu_op_e          op;
        phys_reg_t        prd;
        phys_reg_t        prs1;
        phys_reg_t        prs2;
        logic             rdy1;
        logic             rdy2;
        logic [`IMM_W-1:0] imm;
        rob_id_t          rob_id;
    } dispatch_t;

    typedef struct packed {
        arch_reg_t        rd;
        logic [`XLEN-1:0] value;
    } retire_t;

endpackage

`default_nettype wire

/* design/cdb_if.sv */
`default_nettype none

`include "ooo_macros.svh"

interface cdb_if import ooo_pkg::*; ();

    logic             valid;
    rob_id_t          rob_id;
    phys_reg_t        prd;
    logic [`XLEN-1:0] value;

    // One ALU drives the bus, everyone else snoops it
    modport producer (output valid, output rob_id, output prd, output value);
    modport listener (input valid, input rob_id, input prd, input value);

endinterface

`default_nettype wire

/* design/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic empty,
    output logic full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T               mem [DEPTH];
    logic [AW-1:0]  head;
    logic [AW-1:0]  tail;
    logic [CW-1:0]  count;

    // Head entry is visible without a read strobe
    assign pop_data = mem[head];
    assign empty    = (count == '0);
    assign full     = (count == CW'(DEPTH));

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == AW'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == AW'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count <= count + CW'(push) - CW'(pop);
        end
        if (push) begin
            mem[tail] <= push_data;
        end
    end

endmodule

`default_nettype wire

/* design/rename_stage.sv */
`default_nettype none

`include "ooo_macros.svh"

module rename_stage import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      q_empty,
    input  uop_t      q_data,
    output logic      q_pop,
    input  logic      rob_full,
    input  rob_id_t   rob_next_id,
    input  logic      iq_full,
    output logic      disp_valid,
    output dispatch_t disp_data,
    output arch_reg_t disp_rd,
    output phys_reg_t disp_old_prd,
    input  logic      free_valid,
    input  phys_reg_t free_prd,
    cdb_if.listener   cdb
);

    localparam int FREE_INIT = `PHYS_REGS - `ARCH_REGS;
    localparam int FCW       = $clog2(`PHYS_REGS + 1);

    phys_reg_t              rat     [`ARCH_REGS];
    phys_reg_t              fl_mem  [`PHYS_REGS];
    phys_reg_t              fl_head;
    phys_reg_t              fl_tail;
    logic [FCW-1:0]         fl_count;
    logic [`PHYS_REGS-1:0]  ready;

    logic      needs_prd;
    logic      alloc;
    phys_reg_t new_prd;
    phys_reg_t prs1;
    phys_reg_t prs2;
    logic      rdy1;
    logic      rdy2;

    // x0 writes take no physical register
    assign needs_prd = (q_data.rd != '0);
    assign q_pop     = !q_empty && !rob_full && !iq_full &&
                       (!needs_prd || (fl_count != '0));
    assign alloc     = q_pop && needs_prd;
    assign new_prd   = needs_prd ? fl_mem[fl_head] : '0;

    assign prs1 = rat[q_data.rs1];
    assign prs2 = rat[q_data.rs2];

    // Catch a broadcast landing in the rename cycle itself
    assign rdy1 = ready[prs1] || (cdb.valid && (cdb.prd == prs1));
    assign rdy2 = (q_data.op == ALU_ADDI) || ready[prs2] ||
                  (cdb.valid && (cdb.prd == prs2));

    // RAT, free list and ready bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                rat[i] <= phys_reg_t'(i);
            end
            for (int i = 0; i < FREE_INIT; i++) begin
                fl_mem[i] <= phys_reg_t'(`ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= phys_reg_t'(FREE_INIT);
            fl_count <= FCW'(FREE_INIT);
            ready    <= '1;
        end else begin
            if (cdb.valid) begin
                ready[cdb.prd] <= 1'b1;
            end
            if (alloc) begin
                rat[q_data.rd] <= new_prd;
                ready[new_prd] <= 1'b0;
                // Pointers wrap on their own width
                fl_head        <= fl_head + 1'b1;
            end
            if (free_valid) begin
                fl_mem[fl_tail] <= free_prd;
                fl_tail         <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + FCW'(free_valid) - FCW'(alloc);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= q_pop;
        end
        if (q_pop) begin
            disp_data <= '{
                op:     q_data.op,
                prd:    new_prd,
                prs1:   prs1,
                prs2:   prs2,
                rdy1:   rdy1,
                rdy2:   rdy2,
                imm:    q_data.imm,
                rob_id: rob_next_id
            };
            disp_rd      <= q_data.rd;
            disp_old_prd <= rat[q_data.rd];
        end
    end

endmodule

`default_nettype wire

/* design/issue_queue.sv */
`default_nettype none

`include "ooo_macros.svh"

module issue_queue import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      disp_valid,
    input  dispatch_t disp_data,
    output logic      full,
    cdb_if.listener   cdb,
    output logic      issue_valid,
    output dispatch_t issue_data
);

    localparam int CW = $clog2(`IQ_DEPTH + 1);
    localparam int IW = $clog2(`IQ_DEPTH);

    // Slot 0 holds the oldest entry, valid entries form a prefix
    dispatch_t     ent  [`IQ_DEPTH];
    dispatch_t     woke [`IQ_DEPTH];
    dispatch_t     nxt  [`IQ_DEPTH];
    logic [CW-1:0] count;
    logic [CW-1:0] keep;
    logic          sel_found;
    logic [IW-1:0] sel_idx;

    function automatic dispatch_t wake(dispatch_t e, logic v, phys_reg_t p);
        dispatch_t r;
        r = e;
        if (v && (e.prs1 == p)) begin
            r.rdy1 = 1'b1;
        end
        if (v && (e.prs2 == p)) begin
            r.rdy2 = 1'b1;
        end
        return r;
    endfunction

    // Counts the write still in flight from rename
    assign full = (count + CW'(disp_valid)) >= CW'(`IQ_DEPTH);

    // Oldest entry with both sources ready
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (!sel_found && (i < count) && ent[i].rdy1 && ent[i].rdy2) begin
                sel_found = 1'b1;
                sel_idx   = IW'(i);
            end
        end
    end

    // Wakeup, collapse over the issued slot, append at the end
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            woke[i] = wake(ent[i], cdb.valid, cdb.prd);
        end
        for (int i = 0; i < `IQ_DEPTH - 1; i++) begin
            nxt[i] = (sel_found && (i >= sel_idx)) ? woke[i + 1] : woke[i];
        end
        nxt[`IQ_DEPTH - 1] = woke[`IQ_DEPTH - 1];
        keep = count - CW'(sel_found);
        if (disp_valid) begin
            nxt[keep[IW-1:0]] = wake(disp_data, cdb.valid, cdb.prd);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count       <= '0;
            issue_valid <= 1'b0;
        end else begin
            count       <= keep + CW'(disp_valid);
            issue_valid <= sel_found;
        end
        if (sel_found) begin
            issue_data <= ent[sel_idx];
        end
        ent <= nxt;
    end

endmodule

`default_nettype wire

/* design/execute_unit.sv */
`default_nettype none

`include "ooo_macros.svh"

module execute_unit import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_valid,
    input  dispatch_t issue_data,
    cdb_if.producer   cdb
);

    logic [`XLEN-1:0] prf [`PHYS_REGS];

    logic             s1_valid;
    alu_op_e          s1_op;
    phys_reg_t        s1_prd;
    rob_id_t          s1_rob_id;
    logic [`XLEN-1:0] s1_a;
    logic [`XLEN-1:0] s1_b;
    logic [`XLEN-1:0] alu_res;

    // Register file, written back from the CDB
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                prf[i] <= '0;
            end
        end else if (cdb.valid) begin
            prf[cdb.prd] <= cdb.value;
        end
    end

    // Stage 1 operand read, ADDI takes the sign-extended immediate
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
        s1_op     <= issue_data.op;
        s1_prd    <= issue_data.prd;
        s1_rob_id <= issue_data.rob_id;
        s1_a      <= prf[issue_data.prs1];
        if (issue_data.op == ALU_ADDI) begin
            s1_b <= {{(`XLEN - `IMM_W){issue_data.imm[`IMM_W-1]}}, issue_data.imm};
        end else begin
            s1_b <= prf[issue_data.prs2];
        end
    end

    always_comb begin
        case (s1_op)
            ALU_ADD, ALU_ADDI: alu_res = s1_a + s1_b;
            ALU_SUB:           alu_res = s1_a - s1_b;
            ALU_AND:           alu_res = s1_a & s1_b;
            ALU_OR:            alu_res = s1_a | s1_b;
            ALU_XOR:           alu_res = s1_a ^ s1_b;
            default:           alu_res = '0;
        endcase
    end

    // Stage 2 broadcast, p0 belongs to x0 and stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= s1_valid;
        end
        cdb.rob_id <= s1_rob_id;
        cdb.prd    <= s1_prd;
        cdb.value  <= (s1_prd == '0) ? '0 : alu_res;
    end

endmodule

`default_nettype wire

/* design/reorder_buffer.sv */
`default_nettype none

`include "ooo_macros.svh"

module reorder_buffer import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      disp_valid,
    input  dispatch_t disp_data,
    input  arch_reg_t disp_rd,
    input  phys_reg_t disp_old_prd,
    output logic      full,
    output rob_id_t   next_id,
    cdb_if.listener   cdb,
    input  logic      can_accept,
    output logic      commit_valid,
    output retire_t   commit_data,
    output logic      free_valid,
    output phys_reg_t free_prd
);

    localparam int CW = $clog2(`ROB_DEPTH + 1);

    arch_reg_t              rd_mem      [`ROB_DEPTH];
    phys_reg_t              old_prd_mem [`ROB_DEPTH];
    logic [`XLEN-1:0]       value_mem   [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]  done;
    rob_id_t                head;
    rob_id_t                tail;
    logic [CW-1:0]          count;

    // Rename works one op ahead of the registered dispatch
    assign full    = (count + CW'(disp_valid)) >= CW'(`ROB_DEPTH);
    assign next_id = tail + rob_id_t'(disp_valid);

    assign commit_valid = (count != '0) && done[head] && can_accept;
    assign commit_data  = '{rd: rd_mem[head], value: value_mem[head]};

    // Release the mapping that this op replaced, p0 is never recycled
    assign free_prd   = old_prd_mem[head];
    assign free_valid = commit_valid && (free_prd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (disp_valid) begin
                tail                    <= tail + 1'b1;
                done[disp_data.rob_id]  <= 1'b0;
            end
            if (cdb.valid) begin
                done[cdb.rob_id] <= 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            count <= count + CW'(disp_valid) - CW'(commit_valid);
        end
        if (disp_valid) begin
            rd_mem[disp_data.rob_id]      <= disp_rd;
            old_prd_mem[disp_data.rob_id] <= disp_old_prd;
        end
        if (cdb.valid) begin
            value_mem[cdb.rob_id] <= cdb.value;
        end
    end

endmodule

`default_nettype wire

/* design/retire_port.sv */
`default_nettype none

`include "ooo_macros.svh"

module retire_port import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    commit_valid,
    input  retire_t commit_data,
    output logic    can_accept,
    output logic    retire_valid,
    output retire_t retire_data,
    input  logic    out_credit
);

    localparam int CW = $clog2(`OUT_CREDITS + 1);

    logic          buf_empty;
    logic          buf_full;
    logic [CW-1:0] credit_cnt;

    sync_fifo #(
        .T     (retire_t),
        .DEPTH (`OUT_CREDITS)
    ) retire_buf (
        .clk       (clk),
        .rst       (rst),
        .push      (commit_valid),
        .push_data (commit_data),
        .pop       (retire_valid),
        .pop_data  (retire_data),
        .empty     (buf_empty),
        .full      (buf_full)
    );

    assign can_accept = !buf_full;

    // One record per cycle while the sink has room
    assign retire_valid = !buf_empty && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CW'(`OUT_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CW'(retire_valid) + CW'(out_credit);
        end
    end

endmodule

`default_nettype wire

/* design/ooo_core_top.sv */
`default_nettype none

`include "ooo_macros.svh"

module ooo_core_top import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  uop_t    in_uop,
    output logic    in_credit,
    output logic    retire_valid,
    output retire_t retire_data,
    input  logic    out_credit
);

    logic      q_empty;
    uop_t      q_data;
    logic      rob_full;
    rob_id_t   rob_next_id;
    logic      iq_full;
    logic      disp_valid;
    dispatch_t disp_data;
    arch_reg_t disp_rd;
    phys_reg_t disp_old_prd;
    logic      free_valid;
    phys_reg_t free_prd;
    logic      issue_valid;
    dispatch_t issue_data;
    logic      can_accept;
    logic      commit_valid;
    retire_t   commit_data;

    cdb_if cdb ();

    // Each pop from the queue hands one credit back to the source
    sync_fifo #(
        .T     (uop_t),
        .DEPTH (`INQ_DEPTH)
    ) inst_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (in_valid),
        .push_data (in_uop),
        .pop       (in_credit),
        .pop_data  (q_data),
        .empty     (q_empty),
        .full      ()
    );

    rename_stage rename_inst (
        .clk          (clk),
        .rst          (rst),
        .q_empty      (q_empty),
        .q_data       (q_data),
        .q_pop        (in_credit),
        .rob_full     (rob_full),
        .rob_next_id  (rob_next_id),
        .iq_full      (iq_full),
        .disp_valid   (disp_valid),
        .disp_data    (disp_data),
        .disp_rd      (disp_rd),
        .disp_old_prd (disp_old_prd),
        .free_valid   (free_valid),
        .free_prd     (free_prd),
        .cdb          (cdb.listener)
    );

    issue_queue iq_inst (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_data   (disp_data),
        .full        (iq_full),
        .cdb         (cdb.listener),
        .issue_valid (issue_valid),
        .issue_data  (issue_data)
    );

    execute_unit exec_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .cdb         (cdb.producer)
    );

    reorder_buffer rob_inst (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .disp_data    (disp_data),
        .disp_rd      (disp_rd),
        .disp_old_prd (disp_old_prd),
        .full         (rob_full),
        .next_id      (rob_next_id),
        .cdb          (cdb.listener),
        .can_accept   (can_accept),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .free_valid   (free_valid),
        .free_prd     (free_prd)
    );

    retire_port retire_inst (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .can_accept   (can_accept),
        .retire_valid (retire_valid),
        .retire_data  (retire_data),
        .out_credit   (out_credit)
    );

endmodule

`default_nettype wire

/* sim/ooo_core_assert.sv */
`default_nettype none

`include "ooo_macros.svh"

module ooo_core_assert (
    input logic                              clk,
    input logic                              rst,
    input logic                              retire_valid,
    input logic                              out_credit,
    input logic [$clog2(`OUT_CREDITS+1)-1:0] credit_cnt
);

    localparam int CW = $clog2(`OUT_CREDITS + 1);

    logic [CW-1:0] in_flight;

    // Records handed to the sink and not yet paid back
    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + CW'(retire_valid) - CW'(out_credit);
        end
    end

    // No record leaves without a credit in hand
    credit_gate: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> (in_flight < CW'(`OUT_CREDITS)))
        else $error("retire_valid raised with every output credit in use");

    reset_quiet: assert property (@(posedge clk) rst |=> !retire_valid)
        else $error("retire_valid high right after reset");

    // Sink never returns more than it was given
    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= CW'(`OUT_CREDITS))
        else $error("output credit count above its starting value");

endmodule

bind retire_port ooo_core_assert assert_inst (
    .clk          (clk),
    .rst          (rst),
    .retire_valid (retire_valid),
    .out_credit   (out_credit),
    .credit_cnt   (credit_cnt)
);

`default_nettype wire

/* sim/tb_ooo_core.sv */
`default_nettype none

`include "ooo_macros.svh"

module tb_ooo_core import ooo_pkg::*; ();

    localparam int DIRECTED_OPS    = 60;
    localparam int RANDOM_OPS      = 300;
    localparam int STALL_CYCLES    = 150;
    localparam int WATCHDOG_CYCLES = 200 * (DIRECTED_OPS + RANDOM_OPS) + STALL_CYCLES;

    // Sink behavior for returning output credits
    localparam int SINK_PROMPT = 0;
    localparam int SINK_HOLD   = 1;
    localparam int SINK_RANDOM = 2;

    logic    clk = 1'b0;
    logic    rst = 1'b1;
    logic    in_valid;
    uop_t    in_uop;
    logic    in_credit;
    logic    retire_valid;
    retire_t retire_data;
    logic    out_credit;

    uop_t             send_q [$];
    retire_t          exp_q  [$];
    logic [`XLEN-1:0] ref_regs [`ARCH_REGS];
    int               ops_sent     = 0;
    int               credits_back = 0;
    int               retired_cnt  = 0;
    int               sink_held    = 0;
    int               sink_mode    = 0;
    int               seed;
    logic [31:0]      coin;

    ooo_core_top ooo_core_top_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_uop       (in_uop),
        .in_credit    (in_credit),
        .retire_valid (retire_valid),
        .retire_data  (retire_data),
        .out_credit   (out_credit)
    );

    always #10 clk = ~clk;

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(string msg);
        abort_run($sformatf("Fail at %0t: %s", $time, msg));
    endtask

    task automatic check_retire(retire_t expected, retire_t actual);
        if (actual !== expected) begin
            report_mismatch($sformatf("retire x%0d = %08h, expected x%0d = %08h",
                actual.rd, actual.value, expected.rd, expected.value));
        end
    endtask

    task automatic check_credit(string what, int expected, int actual);
        if (actual != expected) begin
            report_mismatch($sformatf("%s is %0d, expected %0d", what, actual, expected));
        end
    endtask

    // Architectural result of one op in program order
    function automatic retire_t ref_exec(uop_t u);
        logic [`XLEN-1:0]        a;
        logic [`XLEN-1:0]        b;
        logic signed [`XLEN-1:0] imm_ext;
        logic [`XLEN-1:0]        res;
        retire_t                 r;
        a       = (u.rs1 == '0) ? '0 : ref_regs[u.rs1];
        b       = (u.rs2 == '0) ? '0 : ref_regs[u.rs2];
        imm_ext = $signed(u.imm);
        case (u.op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_ADDI: res = a + imm_ext;
            default:  res = '0;
        endcase
        r.rd    = u.rd;
        r.value = (u.rd == '0) ? '0 : res;
        if (u.rd != '0) begin
            ref_regs[u.rd] = res;
        end
        return r;
    endfunction

    function automatic uop_t make_uop(alu_op_e op, int rd, int rs1, int rs2, int imm);
        uop_t u;
        u.op  = op;
        u.rd  = arch_reg_t'(rd);
        u.rs1 = arch_reg_t'(rs1);
        u.rs2 = arch_reg_t'(rs2);
        u.imm = imm[`IMM_W-1:0];
        return u;
    endfunction

    task automatic send_op(uop_t u);
        send_q.push_back(u);
        exp_q.push_back(ref_exec(u));
    endtask

    task automatic wait_drain();
        while (send_q.size() != 0 || exp_q.size() != 0 || sink_held != 0) begin
            @(posedge clk);
        end
    endtask

    // Source side, a credit seen now is spent from the next cycle on
    always @(negedge clk) begin
        uop_t next_uop;
        if (rst) begin
            in_valid <= 1'b0;
        end else begin
            if (send_q.size() != 0 && (ops_sent - credits_back) < `INQ_DEPTH) begin
                next_uop = send_q.pop_front();
                in_uop   <= next_uop;
                in_valid <= 1'b1;
                ops_sent++;
            end else begin
                in_valid <= 1'b0;
            end
            if (in_credit) begin
                credits_back++;
                if (credits_back > ops_sent) begin
                    report_mismatch("in_credit pulsed more often than ops were sent");
                end
            end
        end
    end

    // Sink side credit return
    always @(negedge clk) begin
        if (rst) begin
            out_credit <= 1'b0;
        end else begin
            if (retire_valid) begin
                sink_held++;
            end
            coin = $random(seed);
            if (sink_held != 0 && (sink_mode == SINK_PROMPT ||
                                   (sink_mode == SINK_RANDOM && coin[0]))) begin
                out_credit <= 1'b1;
                sink_held--;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    // Compare each retire record against the reference
    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            if (exp_q.size() == 0) begin
                report_mismatch("retire record with no op outstanding");
            end else begin
                check_retire(exp_q.pop_front(), retire_data);
                retired_cnt++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("Timeout after %0d cycles with %0d records still expected",
            WATCHDOG_CYCLES, exp_q.size()));
    end

    initial begin
        int          base;
        int          prev;
        int          cur;
        logic [31:0] r1;
        logic [31:0] r2;
        in_valid   = 1'b0;
        in_uop     = '0;
        out_credit = 1'b0;
        seed       = 32'hc7ca;
        sink_mode  = SINK_PROMPT;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            ref_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Loads, then one of each register op
        for (int i = 1; i < `ARCH_REGS; i++) begin
            send_op(make_uop(ALU_ADDI, i, 0, 0, i * 1111 - 4000));
        end
        send_op(make_uop(ALU_ADD, 1, 2, 3, 0));
        send_op(make_uop(ALU_SUB, 2, 4, 7, 0));
        send_op(make_uop(ALU_AND, 3, 5, 6, 0));
        send_op(make_uop(ALU_OR,  4, 1, 2, 0));
        send_op(make_uop(ALU_XOR, 5, 3, 4, 0));
        wait_drain();

        // Each op reads the rd just written
        prev = 1;
        send_op(make_uop(ALU_ADDI, 1, 1, 0, 12345));
        for (int i = 0; i < 13; i++) begin
            cur = (prev % 7) + 1;
            send_op(make_uop(alu_op_e'(i % 6), cur, prev, cur, -(i * 37)));
            prev = cur;
        end
        wait_drain();

        // x0 as destination and as source
        send_op(make_uop(ALU_ADDI, 0, 3, 0, 77));
        send_op(make_uop(ALU_ADD,  0, 1, 2, 0));
        send_op(make_uop(ALU_ADD,  4, 0, 5, 0));
        send_op(make_uop(ALU_ADDI, 6, 0, 0, -1));
        send_op(make_uop(ALU_SUB,  7, 0, 2, 0));
        send_op(make_uop(ALU_XOR,  1, 0, 0, 0));
        wait_drain();

        // Sink withholds credits, the whole pipe backs up
        sink_mode = SINK_HOLD;
        base      = retired_cnt;
        for (int i = 0; i < 24; i++) begin
            send_op(make_uop(alu_op_e'(i % 6), (i % 7) + 1, (i % 5) + 1, (i % 3) + 2,
                             i * 99));
        end
        repeat (STALL_CYCLES) @(posedge clk);
        check_credit("retire records while credits withheld", `OUT_CREDITS,
                     retired_cnt - base);
        if (send_q.size() == 0) begin
            abort_run("The source was never held back by missing input credits");
        end
        sink_mode = SINK_PROMPT;
        wait_drain();

        // Long random run well past the physical register count
        sink_mode = SINK_RANDOM;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            send_op(make_uop(alu_op_e'(r1 % 6), r1[5:3], r1[8:6], r1[11:9], r2[15:0]));
        end
        wait_drain();

        check_credit("in_credit pulses against ops sent", ops_sent, credits_back);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/ooo_pkg.sv
design/cdb_if.sv
design/sync_fifo.sv
design/rename_stage.sv
design/issue_queue.sv
design/execute_unit.sv
design/reorder_buffer.sv
design/retire_port.sv
design/ooo_core_top.sv
sim/ooo_core_assert.sv
sim/tb_ooo_core.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench, exit status follows the simulation
verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_ooo_core \
    && ./obj_dir/Vtb_ooo_core \
    || exit 1
